//--- design/fe_pkg.sv
package fe_pkg;

  // register file sizes
  localparam int NUM_ARCH_REG = 8;
  localparam int NUM_PHYS_REG = 16;
  localparam int NUM_FREE_REG = NUM_PHYS_REG - NUM_ARCH_REG;

  // index and word widths
  localparam int ARCH_W    = 3;
  localparam int PHYS_W    = 4;
  localparam int ROB_DEPTH = 8;
  localparam int ROB_PTR_W = 3;
  localparam int INSTR_W   = 16;

  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_LD  = 4'd5,
    OP_ST  = 4'd6,
    OP_BR  = 4'd7
  } opcode_e;

  // alu ops and loads produce a result
  function automatic logic op_writes(input opcode_e op);
    return (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_LD});
  endfunction

  // everything but nop has a base or first operand
  function automatic logic op_reads_src1(input opcode_e op);
    return (op != OP_NOP);
  endfunction

  // load uses only the base register
  function automatic logic op_reads_src2(input opcode_e op);
    return (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ST, OP_BR});
  endfunction

endpackage

//--- design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [fe_pkg::INSTR_W-1:0]  instr_i,
  input  logic                        instr_v_i,
  output logic                        instr_ready_o,
  input  logic                        flush_i,
  output logic                        dec_v_o,
  output fe_pkg::opcode_e             dec_op_o,
  output logic [fe_pkg::ARCH_W-1:0]   dec_dest_o,
  output logic [fe_pkg::ARCH_W-1:0]   dec_src1_o,
  output logic [fe_pkg::ARCH_W-1:0]   dec_src2_o,
  output logic                        dec_misp_o,
  output logic                        dec_wr_o,
  input  logic                        dec_ready_i
);
  import fe_pkg::*;

  logic [INSTR_W-1:0] instr_q;
  logic               valid_q;
  logic [3:0]         raw_op;

  // slot is free when empty or drained this cycle
  assign instr_ready_o = (!valid_q || dec_ready_i) && !flush_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
      valid_q <= 1'b0;
    else if (instr_ready_o)
      valid_q <= instr_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (instr_v_i && instr_ready_o)
      instr_q <= instr_i;
  end

  // field split of the held word
  assign raw_op = instr_q[INSTR_W-1 -: 4];

  always_comb
  begin
    // codes above the branch are not defined
    if (raw_op <= 4'(OP_BR))
      dec_op_o = opcode_e'(raw_op);
    else
      dec_op_o = OP_NOP;
  end

  assign dec_v_o    = valid_q;
  assign dec_dest_o = instr_q[11 -: ARCH_W];
  assign dec_src1_o = instr_q[8 -: ARCH_W];
  assign dec_src2_o = instr_q[5 -: ARCH_W];
  assign dec_misp_o = instr_q[0];
  assign dec_wr_o   = op_writes(dec_op_o);

endmodule

//--- design/rename_stage.sv
`timescale 1ns/10ps

module rename_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        dec_v_i,
  input  fe_pkg::opcode_e             dec_op_i,
  input  logic [fe_pkg::ARCH_W-1:0]   dec_dest_i,
  input  logic [fe_pkg::ARCH_W-1:0]   dec_src1_i,
  input  logic [fe_pkg::ARCH_W-1:0]   dec_src2_i,
  input  logic                        dec_misp_i,
  input  logic                        dec_wr_i,
  output logic                        dec_ready_o,
  input  logic                        issue_ready_i,
  output logic                        issue_v_o,
  output fe_pkg::opcode_e             issue_op_o,
  output logic [fe_pkg::PHYS_W-1:0]   issue_src1_o,
  output logic [fe_pkg::PHYS_W-1:0]   issue_src2_o,
  output logic [fe_pkg::PHYS_W-1:0]   issue_dest_o,
  input  logic                        rob_ready_i,
  output logic                        rob_alloc_v_o,
  output logic [fe_pkg::ARCH_W-1:0]   rob_arch_o,
  output logic [fe_pkg::PHYS_W-1:0]   rob_phys_o,
  output logic [fe_pkg::PHYS_W-1:0]   rob_freed_o,
  output logic                        rob_wr_o,
  output fe_pkg::opcode_e             rob_op_o,
  output logic                        rob_misp_o,
  input  logic                        ret_v_i,
  input  logic                        ret_wr_i,
  input  logic [fe_pkg::PHYS_W-1:0]   ret_phys_i,
  input  logic [fe_pkg::ARCH_W-1:0]   ret_arch_i,
  input  logic [fe_pkg::PHYS_W-1:0]   ret_freed_i,
  input  logic                        ret_rollback_i
);
  import fe_pkg::*;

  // speculative and committed rename state
  logic [PHYS_W-1:0] spec_map [NUM_ARCH_REG];
  logic [PHYS_W-1:0] cmt_map  [NUM_ARCH_REG];
  logic [PHYS_W-1:0] spec_fl  [NUM_PHYS_REG];
  logic [PHYS_W-1:0] cmt_fl   [NUM_PHYS_REG];
  logic [PHYS_W-1:0] spec_rd;
  logic [PHYS_W-1:0] spec_wr;
  logic [PHYS_W-1:0] cmt_rd;
  logic [PHYS_W-1:0] cmt_wr;
  logic [PHYS_W:0]   spec_cnt;

  logic              accept;
  logic              alloc;
  logic              free_ret;
  logic [PHYS_W-1:0] new_phys;
  logic [PHYS_W-1:0] src1_phys;
  logic [PHYS_W-1:0] src2_phys;

  assign dec_ready_o = (spec_cnt != '0 || !dec_wr_i) && rob_ready_i && issue_ready_i
                       && !ret_rollback_i;
  assign accept   = dec_v_i && dec_ready_o;
  assign alloc    = accept && dec_wr_i;
  assign free_ret = ret_v_i && ret_wr_i && !ret_rollback_i;

  assign new_phys  = dec_wr_i ? spec_fl[spec_rd] : '0;
  assign src1_phys = op_reads_src1(dec_op_i) ? spec_map[dec_src1_i] : '0;
  assign src2_phys = op_reads_src2(dec_op_i) ? spec_map[dec_src2_i] : '0;

  // reorder buffer entry, written on accept
  assign rob_alloc_v_o = accept;
  assign rob_arch_o    = dec_dest_i;
  assign rob_phys_o    = new_phys;
  assign rob_freed_o   = spec_map[dec_dest_i];
  assign rob_wr_o      = dec_wr_i;
  assign rob_op_o      = dec_op_i;
  assign rob_misp_o    = dec_misp_i;

  // speculative tables
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_ARCH_REG; i++)
        spec_map[i] <= PHYS_W'(i);
      for (int i = 0; i < NUM_PHYS_REG; i++)
        spec_fl[i] <= PHYS_W'(i + NUM_ARCH_REG);
      spec_rd  <= '0;
      spec_wr  <= PHYS_W'(NUM_FREE_REG);
      spec_cnt <= (PHYS_W+1)'(NUM_FREE_REG);
    end
    else if (ret_rollback_i)
    begin
      // committed side always owns the full free set
      spec_map <= cmt_map;
      spec_fl  <= cmt_fl;
      spec_rd  <= cmt_rd;
      spec_wr  <= cmt_wr;
      spec_cnt <= (PHYS_W+1)'(NUM_FREE_REG);
    end
    else
    begin
      if (alloc)
      begin
        spec_map[dec_dest_i] <= new_phys;
        spec_rd <= spec_rd + 1'b1;
      end
      if (free_ret)
      begin
        spec_fl[spec_wr] <= ret_freed_i;
        spec_wr <= spec_wr + 1'b1;
      end
      spec_cnt <= spec_cnt + (PHYS_W+1)'(free_ret) - (PHYS_W+1)'(alloc);
    end
  end

  // committed tables, advanced by writing retirements
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_ARCH_REG; i++)
        cmt_map[i] <= PHYS_W'(i);
      for (int i = 0; i < NUM_PHYS_REG; i++)
        cmt_fl[i] <= PHYS_W'(i + NUM_ARCH_REG);
      cmt_rd <= '0;
      cmt_wr <= PHYS_W'(NUM_FREE_REG);
    end
    else if (free_ret)
    begin
      cmt_map[ret_arch_i] <= ret_phys_i;
      cmt_fl[cmt_wr] <= ret_freed_i;
      cmt_wr <= cmt_wr + 1'b1;
      cmt_rd <= cmt_rd + 1'b1;
    end
  end

  // issue register holds while issue is stalled
  always_ff @(posedge clk_i)
  begin
    if (reset_i || ret_rollback_i)
      issue_v_o <= 1'b0;
    else if (issue_ready_i)
      issue_v_o <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      issue_op_o   <= dec_op_i;
      issue_src1_o <= src1_phys;
      issue_src2_o <= src2_phys;
      issue_dest_o <= new_phys;
    end
  end

endmodule

//--- design/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        rob_alloc_v_i,
  input  fe_pkg::opcode_e             rob_op_i,
  input  logic [fe_pkg::ARCH_W-1:0]   rob_arch_i,
  input  logic [fe_pkg::PHYS_W-1:0]   rob_phys_i,
  input  logic [fe_pkg::PHYS_W-1:0]   rob_freed_i,
  input  logic                        rob_wr_i,
  input  logic                        rob_misp_i,
  output logic                        rob_ready_o,
  input  logic                        retire_en_i,
  output logic                        ret_v_o,
  output logic                        ret_wr_o,
  output logic [fe_pkg::ARCH_W-1:0]   ret_arch_o,
  output logic [fe_pkg::PHYS_W-1:0]   ret_phys_o,
  output logic [fe_pkg::PHYS_W-1:0]   ret_freed_o,
  output logic                        ret_rollback_o,
  output logic                        commit_v_o,
  output logic [fe_pkg::ARCH_W-1:0]   commit_arch_o,
  output logic [fe_pkg::PHYS_W-1:0]   commit_phys_o,
  output logic [fe_pkg::PHYS_W-1:0]   commit_freed_o,
  output logic                        commit_wr_o,
  output logic                        flush_o
);
  import fe_pkg::*;

  // entry storage
  opcode_e              op_q    [ROB_DEPTH];
  logic [ARCH_W-1:0]    arch_q  [ROB_DEPTH];
  logic [PHYS_W-1:0]    phys_q  [ROB_DEPTH];
  logic [PHYS_W-1:0]    freed_q [ROB_DEPTH];
  logic                 wr_q    [ROB_DEPTH];
  logic                 misp_q  [ROB_DEPTH];

  logic [ROB_PTR_W-1:0] head_q;
  logic [ROB_PTR_W-1:0] tail_q;
  logic [ROB_PTR_W:0]   count_q;
  logic                 retire;

  assign rob_ready_o = (count_q != (ROB_PTR_W+1)'(ROB_DEPTH));
  assign retire      = retire_en_i && (count_q != '0);

  // head entry leaves this cycle
  assign ret_v_o     = retire;
  assign ret_wr_o    = retire && wr_q[head_q];
  assign ret_arch_o  = arch_q[head_q];
  assign ret_phys_o  = phys_q[head_q];
  assign ret_freed_o = freed_q[head_q];

  // a mispredicted branch at the head squashes everything behind it
  assign ret_rollback_o = retire && (op_q[head_q] == OP_BR) && misp_q[head_q];

  always_ff @(posedge clk_i)
  begin
    if (rob_alloc_v_i)
    begin
      op_q[tail_q]    <= rob_op_i;
      arch_q[tail_q]  <= rob_arch_i;
      phys_q[tail_q]  <= rob_phys_i;
      freed_q[tail_q] <= rob_freed_i;
      wr_q[tail_q]    <= rob_wr_i;
      misp_q[tail_q]  <= rob_misp_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i || ret_rollback_o)
    begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end
    else
    begin
      if (rob_alloc_v_i)
        tail_q <= tail_q + 1'b1;
      if (retire)
        head_q <= head_q + 1'b1;
      count_q <= count_q + (ROB_PTR_W+1)'(rob_alloc_v_i) - (ROB_PTR_W+1)'(retire);
    end
  end

  // commit port, one cycle behind retirement
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      commit_v_o <= 1'b0;
      flush_o    <= 1'b0;
    end
    else
    begin
      commit_v_o <= retire;
      flush_o    <= ret_rollback_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (retire)
    begin
      commit_arch_o  <= arch_q[head_q];
      commit_phys_o  <= phys_q[head_q];
      commit_freed_o <= freed_q[head_q];
      commit_wr_o    <= wr_q[head_q];
    end
  end

endmodule

//--- design/frontend_top.sv
`timescale 1ns/10ps

module frontend_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [fe_pkg::INSTR_W-1:0]  instr_i,
  input  logic                        instr_v_i,
  output logic                        instr_ready_o,
  input  logic                        issue_ready_i,
  input  logic                        retire_en_i,
  output logic                        issue_v_o,
  output fe_pkg::opcode_e             issue_op_o,
  output logic [fe_pkg::PHYS_W-1:0]   issue_src1_o,
  output logic [fe_pkg::PHYS_W-1:0]   issue_src2_o,
  output logic [fe_pkg::PHYS_W-1:0]   issue_dest_o,
  output logic                        commit_v_o,
  output logic [fe_pkg::ARCH_W-1:0]   commit_arch_o,
  output logic [fe_pkg::PHYS_W-1:0]   commit_phys_o,
  output logic [fe_pkg::PHYS_W-1:0]   commit_freed_o,
  output logic                        commit_wr_o,
  output logic                        flush_o
);
  import fe_pkg::*;

  // decode to rename
  logic              dec_v;
  opcode_e           dec_op;
  logic [ARCH_W-1:0] dec_dest;
  logic [ARCH_W-1:0] dec_src1;
  logic [ARCH_W-1:0] dec_src2;
  logic              dec_misp;
  logic              dec_wr;
  logic              ren_ready;

  // rename to reorder buffer
  logic              rob_alloc_v;
  opcode_e           rob_op;
  logic [ARCH_W-1:0] rob_arch;
  logic [PHYS_W-1:0] rob_phys;
  logic [PHYS_W-1:0] rob_freed;
  logic              rob_wr;
  logic              rob_misp;
  logic              rob_ready;

  // retirement back to rename
  logic              ret_v;
  logic              ret_wr;
  logic [ARCH_W-1:0] ret_arch;
  logic [PHYS_W-1:0] ret_phys;
  logic [PHYS_W-1:0] ret_freed;
  logic              ret_rollback;

  decode_stage u_decode (
    .clk_i(clk_i), .reset_i(reset_i),
    .instr_i(instr_i), .instr_v_i(instr_v_i), .instr_ready_o(instr_ready_o),
    .flush_i(ret_rollback),
    .dec_v_o(dec_v), .dec_op_o(dec_op), .dec_dest_o(dec_dest),
    .dec_src1_o(dec_src1), .dec_src2_o(dec_src2), .dec_misp_o(dec_misp),
    .dec_wr_o(dec_wr), .dec_ready_i(ren_ready)
  );

  rename_stage u_rename (
    .clk_i(clk_i), .reset_i(reset_i),
    .dec_v_i(dec_v), .dec_op_i(dec_op), .dec_dest_i(dec_dest),
    .dec_src1_i(dec_src1), .dec_src2_i(dec_src2), .dec_misp_i(dec_misp),
    .dec_wr_i(dec_wr), .dec_ready_o(ren_ready),
    .issue_ready_i(issue_ready_i), .issue_v_o(issue_v_o), .issue_op_o(issue_op_o),
    .issue_src1_o(issue_src1_o), .issue_src2_o(issue_src2_o),
    .issue_dest_o(issue_dest_o),
    .rob_ready_i(rob_ready), .rob_alloc_v_o(rob_alloc_v), .rob_arch_o(rob_arch),
    .rob_phys_o(rob_phys), .rob_freed_o(rob_freed), .rob_wr_o(rob_wr),
    .rob_op_o(rob_op), .rob_misp_o(rob_misp),
    .ret_v_i(ret_v), .ret_wr_i(ret_wr), .ret_phys_i(ret_phys), .ret_arch_i(ret_arch),
    .ret_freed_i(ret_freed), .ret_rollback_i(ret_rollback)
  );

  reorder_buffer u_rob (
    .clk_i(clk_i), .reset_i(reset_i),
    .rob_alloc_v_i(rob_alloc_v), .rob_op_i(rob_op), .rob_arch_i(rob_arch),
    .rob_phys_i(rob_phys), .rob_freed_i(rob_freed), .rob_wr_i(rob_wr),
    .rob_misp_i(rob_misp), .rob_ready_o(rob_ready),
    .retire_en_i(retire_en_i),
    .ret_v_o(ret_v), .ret_wr_o(ret_wr), .ret_arch_o(ret_arch), .ret_phys_o(ret_phys),
    .ret_freed_o(ret_freed), .ret_rollback_o(ret_rollback),
    .commit_v_o(commit_v_o), .commit_arch_o(commit_arch_o),
    .commit_phys_o(commit_phys_o), .commit_freed_o(commit_freed_o),
    .commit_wr_o(commit_wr_o), .flush_o(flush_o)
  );

endmodule

//--- tb/frontend_sva.sv
`timescale 1ns/10ps

module rob_checker (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       alloc_v_i,
  input logic                       rob_ready_i,
  input logic                       commit_v_i,
  input logic                       commit_wr_i,
  input logic                       flush_i,
  input logic [fe_pkg::ROB_PTR_W:0] count_i
);
  import fe_pkg::*;

  // no allocation into a full buffer
  alloc_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    alloc_v_i |-> rob_ready_i)
    else $error("allocation while the reorder buffer is full");

  // flush rides on the commit of a branch, which writes no register
  // rename must not have allocated in the rollback cycle
  flush_with_branch: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |-> commit_v_i && !commit_wr_i && !$past(alloc_v_i))
    else $error("flush without a committing branch");

  count_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
    count_i <= (ROB_PTR_W+1)'(ROB_DEPTH))
    else $error("reorder buffer count above depth");

endmodule

bind reorder_buffer rob_checker u_rob_checker (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .alloc_v_i(rob_alloc_v_i),
  .rob_ready_i(rob_ready_o),
  .commit_v_i(commit_v_o),
  .commit_wr_i(commit_wr_o),
  .flush_i(flush_o),
  .count_i(count_q)
);

//--- tb/frontend_tb.sv
`timescale 1ns/10ps

module frontend_tb;
  import fe_pkg::*;

  logic               clk_i;
  logic               reset_i;
  logic [15:0]        instr_i;
  logic               instr_v_i;
  logic               instr_ready_o;
  logic               issue_ready_i;
  logic               retire_en_i;
  logic               issue_v_o;
  opcode_e            issue_op_o;
  logic [3:0]         issue_src1_o;
  logic [3:0]         issue_src2_o;
  logic [3:0]         issue_dest_o;
  logic               commit_v_o;
  logic [2:0]         commit_arch_o;
  logic [3:0]         commit_phys_o;
  logic [3:0]         commit_freed_o;
  logic               commit_wr_o;
  logic               flush_o;

  // reference model state
  logic [3:0]  spec_map [8];
  logic [3:0]  cmt_map  [8];
  logic [3:0]  spec_fl  [$];
  logic [3:0]  cmt_fl   [$];
  logic [15:0] dec_q    [$];
  logic [15:0] issue_q  [$];
  logic [12:0] rob_q    [$];
  logic [15:0] held;
  logic        held_valid;
  logic        issue_ready_prev;
  logic        instr_taken;
  logic [31:0] lfsr;
  int          errors;
  int          n_issued;
  int          n_commits;
  int          n_flushes;

  frontend_top u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] make_word();
    logic [15:0] w;
    w = 16'(rand_bits(16));
    w[15] = (rand_bits(3) == 7);
    w[0] = (rand_bits(2) == 3);
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // rename one decoded word against the speculative state
  task automatic rename_word(input logic [15:0] w);
    logic [3:0] op;
    logic       wr;
    logic [3:0] s1;
    logic [3:0] s2;
    logic [3:0] d;
    logic [3:0] freed;
    logic       rb;
    op = (w[15:12] > 4'd7) ? 4'd0 : w[15:12];
    wr = (op >= 4'd1 && op <= 4'd5);
    s1 = (op != 4'd0) ? spec_map[w[8:6]] : 4'd0;
    s2 = (op != 4'd0 && op != 4'd5) ? spec_map[w[5:3]] : 4'd0;
    freed = spec_map[w[11:9]];
    d = 4'd0;
    if (wr)
    begin
      if (spec_fl.size() == 0)
      begin
        errors++;
        $display("rename allocated with an empty free list");
      end
      else
        d = spec_fl.pop_front();
      spec_map[w[11:9]] = d;
    end
    rb = (op == 4'd7) && w[0];
    issue_q.push_back({op, s1, s2, d});
    rob_q.push_back({rb, wr, w[11:9], d, freed});
  endtask

  task automatic retire_entry();
    logic [12:0] e;
    if (rob_q.size() == 0)
    begin
      errors++;
      $display("commit seen with no instruction in flight");
      return;
    end
    e = rob_q.pop_front();
    n_commits++;
    check("commit_arch", 32'(e[10:8]), 32'(commit_arch_o));
    check("commit_phys", 32'(e[7:4]), 32'(commit_phys_o));
    check("commit_freed", 32'(e[3:0]), 32'(commit_freed_o));
    check("commit_wr", 32'(e[11]), 32'(commit_wr_o));
    check("commit_flush", 32'(e[12]), 32'(flush_o));
    if (e[12])
    begin
      // rollback to the committed copy and squash everything younger
      n_flushes++;
      spec_map = cmt_map;
      spec_fl = cmt_fl;
      rob_q.delete();
      issue_q.delete();
      dec_q.delete();
      held_valid = 1'b0;
    end
    else if (e[11])
    begin
      cmt_map[e[10:8]] = e[7:4];
      void'(cmt_fl.pop_front());
      cmt_fl.push_back(e[3:0]);
      spec_fl.push_back(e[3:0]);
    end
  endtask

  task automatic observe_cycle();
    logic [15:0] now;
    logic [15:0] e;
    now = {4'(issue_op_o), issue_src1_o, issue_src2_o, issue_dest_o};
    // a stalled issue slot holds unless a rollback cleared it
    if (held_valid && !flush_o)
    begin
      check("issue_hold_v", 1, 32'(issue_v_o));
      check("issue_hold", 32'(held), 32'(now));
    end
    if (commit_v_o)
      retire_entry();
    else
      check("flush_idle", 0, 32'(flush_o));
    // issue slot loaded on the last edge means rename took a word
    if (issue_v_o && issue_ready_prev)
    begin
      if (dec_q.size() == 0)
      begin
        errors++;
        $display("rename accepted with no decoded instruction");
      end
      else
        rename_word(dec_q.pop_front());
    end
    if (issue_v_o && issue_ready_i)
    begin
      if (issue_q.size() == 0)
      begin
        errors++;
        $display("unexpected instruction at the issue port");
      end
      else
      begin
        e = issue_q.pop_front();
        n_issued++;
        check("issue_op", 32'(e[15:12]), 32'(issue_op_o));
        check("issue_src1", 32'(e[11:8]), 32'(issue_src1_o));
        check("issue_src2", 32'(e[7:4]), 32'(issue_src2_o));
        check("issue_dest", 32'(e[3:0]), 32'(issue_dest_o));
      end
    end
    held_valid = issue_v_o && !issue_ready_i;
    held = now;
    issue_ready_prev = issue_ready_i;
    instr_taken = instr_v_i && instr_ready_o;
    if (instr_taken)
      dec_q.push_back(instr_i);
  endtask

  always @(negedge clk_i)
  begin
    if (!reset_i)
      observe_cycle();
  end

  initial
  begin
    int t;
    reset_i = 1'b1;
    instr_i = '0;
    instr_v_i = 1'b0;
    issue_ready_i = 1'b0;
    retire_en_i = 1'b0;
    lfsr = 32'h8c3e;
    errors = 0;
    n_issued = 0;
    n_commits = 0;
    n_flushes = 0;
    held_valid = 1'b0;
    issue_ready_prev = 1'b0;
    instr_taken = 1'b0;
    held = '0;
    for (int i = 0; i < 8; i++)
    begin
      spec_map[i] = 4'(i);
      cmt_map[i] = 4'(i);
      spec_fl.push_back(4'(i + 8));
      cmt_fl.push_back(4'(i + 8));
    end
    repeat (8) @(posedge clk_i);
    #2 reset_i = 1'b0;
    check("reset_issue_v", 0, 32'(issue_v_o));
    check("reset_commit_v", 0, 32'(commit_v_o));
    check("reset_flush", 0, 32'(flush_o));
    check("reset_instr_ready", 1, 32'(instr_ready_o));

    for (int cyc = 0; cyc < 900; cyc++)
    begin
      @(posedge clk_i);
      #2;
      // retirement held off long enough to fill the buffer
      if (cyc == 355)
        check("intake_stall", 0, 32'(instr_ready_o));
      if (!instr_v_i || instr_taken)
      begin
        instr_v_i = (cyc >= 300 && cyc < 360) ? 1'b1 : (rand_bits(2) != 0);
        instr_i = make_word();
      end
      if (cyc >= 300 && cyc < 360)
      begin
        retire_en_i = 1'b0;
        issue_ready_i = 1'b1;
      end
      else if (cyc >= 500 && cyc < 530)
      begin
        issue_ready_i = 1'b0;
        retire_en_i = 1'(rand_bits(1));
      end
      else
      begin
        issue_ready_i = (rand_bits(2) != 0);
        retire_en_i = 1'(rand_bits(1));
      end
    end

    // drain the pipeline
    @(posedge clk_i);
    #2;
    instr_v_i = 1'b0;
    issue_ready_i = 1'b1;
    retire_en_i = 1'b1;
    t = 0;
    while (t < 200 && (rob_q.size() != 0 || issue_q.size() != 0 || dec_q.size() != 0))
    begin
      @(posedge clk_i);
      t++;
    end
    if (t >= 200)
    begin
      errors++;
      $display("timeout while waiting for the pipeline to drain");
    end
    repeat (2) @(posedge clk_i);
    $display("errors %0d issued %0d committed %0d flushes %0d",
             errors, n_issued, n_commits, n_flushes);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- build.f
design/fe_pkg.sv
design/decode_stage.sv
design/rename_stage.sv
design/reorder_buffer.sv
design/frontend_top.sv
tb/frontend_sva.sv
tb/frontend_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module frontend_tb -o frontend_sim
./obj_dir/frontend_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TEST PASS" sim.log
